// ==== all.f ====
+incdir+include
+incdir+testbench
logic/fpu_pkg.sv
logic/mem_pkg.sv
logic/job_sequencer.sv
logic/region_walker.sv
logic/elem_datapath.sv
logic/fpu_job_manager.sv
testbench/fpu_job_manager_checker.sv
testbench/tb_fpu_job_manager.sv

// ==== Makefile ====
TOP = tb_fpu_job_manager

.PHONY: sim clean

sim:
	verilator --binary --timing --assert -f all.f --top-module $(TOP)
	out=$$(./obj_dir/V$(TOP)); echo "$$out"; echo "$$out" | grep -qx "Done: no errors"

clean:
	rm -rf obj_dir

// ==== testbench/tb_tests.svh ====
`ifndef TB_TESTS_SVH
`define TB_TESTS_SVH

typedef logic [`DATA_W-1:0] word_q_t[$];

logic [`DATA_W-1:0] lcg_state = 32'd40;
logic [`DATA_W-1:0] exp_mem [MEM_WORDS];
int                 jobs_done = 0;

function automatic logic [`DATA_W-1:0] lcg_next();
  lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
  return lcg_state;
endfunction

function automatic job_desc_t make_job(input op_id_t op, input int base_a,
                                       input int base_b, input int base_d, input int n);
  job_desc_t j;
  j.op     = op;
  j.base_a = `ADDR_W'(base_a);
  j.base_b = `ADDR_W'(base_b);
  j.base_d = `ADDR_W'(base_d);
  j.count  = `COUNT_W'(n);
  return j;
endfunction

task automatic compare_word(input string what, input logic [`DATA_W-1:0] got,
                            input logic [`DATA_W-1:0] exp);
  assert (got === exp) else begin
    $display("Fail at %0t: %s is %h, expected %h", $time, what, got, exp);
    err_count++;
  end
endtask

task automatic compare_int(input string what, input int got, input int exp);
  assert (got == exp) else begin
    $display("Fail at %0t: %s is %0d, expected %0d", $time, what, got, exp);
    err_count++;
  end
endtask

// Whole memory, so stray writes outside D show up too
task automatic compare_memory(input string what);
  for (int i = 0; i < MEM_WORDS; i++)
    compare_word($sformatf("%s mem[%0d]", what, i), mem[8'(i)], exp_mem[8'(i)]);
endtask

task automatic load_words(input int base, input word_q_t words);
  foreach (words[i]) begin
    @(posedge clk);
    load_we   <= 1'b1;
    load_addr <= 8'(base + i);
    load_data <= words[i];
    exp_mem[8'(base + i)] = words[i];
  end
  @(posedge clk);
  load_we <= 1'b0;
endtask

// Four-phase handshake, req held for hold_cycles after ack
task automatic run_job(input job_desc_t j, input int hold_cycles);
  int waited;
  @(posedge clk);
  job <= j;
  req <= 1'b1;
  waited = 0;
  while (!ack && waited < `TB_TIMEOUT) begin
    @(posedge clk);
    waited++;
  end
  assert (ack) else begin
    $display("Timed out waiting for ack to rise");
    timeout_count++;
  end
  repeat (hold_cycles) begin
    @(posedge clk);
    compare_int("ack while req held", int'(ack), 1);
    compare_int("re or we while req held", int'(mem_req.re | mem_req.we), 0);
  end
  req <= 1'b0;
  waited = 0;
  while (ack && waited < `TB_TIMEOUT) begin
    @(posedge clk);
    waited++;
  end
  assert (!ack) else begin
    $display("Timed out waiting for ack to fall");
    timeout_count++;
  end
  jobs_done++;
  compare_int("job_count", int'(job_count), jobs_done);
endtask

task automatic check_reset_state();
  for (int i = 0; i < MEM_WORDS; i++)
    exp_mem[8'(i)] = fill_word(8'(i));
  @(posedge clk);
  compare_int("ack after reset", int'(ack), 0);
  compare_int("re after reset", int'(mem_req.re), 0);
  compare_int("we after reset", int'(mem_req.we), 0);
  compare_int("job_count after reset", int'(job_count), 0);
endtask

task automatic test_relu_fw();
  word_q_t a;
  int      rd0;
  int      wr0;
  repeat (8) a.push_back(lcg_next());
  load_words(0, a);
  rd0 = rd_count;
  wr0 = wr_count;
  run_job(make_job(RELU_FW, 0, 0, 64, 8), 0);
  foreach (a[i])
    exp_mem[8'(64 + i)] = a[i][31] ? '0 : a[i];
  compare_int("relu_fw reads", rd_count - rd0, 8);
  compare_int("relu_fw writes", wr_count - wr0, 8);
  compare_memory("relu_fw");
endtask

task automatic test_relu_bw();
  // +0, -0, -1.0, +1.0, smallest denormal, -100.0, +2.5, negative denormal
  word_q_t a = '{32'h0000_0000, 32'h8000_0000, 32'hBF80_0000, 32'h3F80_0000,
                 32'h0000_0001, 32'hC2C8_0000, 32'h4020_0000, 32'h8000_0001};
  word_q_t b;
  int      rd0;
  int      wr0;
  repeat (8) b.push_back(lcg_next());
  load_words(16, a);
  load_words(32, b);
  rd0 = rd_count;
  wr0 = wr_count;
  run_job(make_job(RELU_BW, 16, 32, 96, 8), 0);
  foreach (a[i])
    exp_mem[8'(96 + i)] = (!a[i][31] && a[i][30:0] != '0) ? b[i] : '0;
  compare_int("relu_bw reads", rd_count - rd0, 16);
  compare_int("relu_bw writes", wr_count - wr0, 8);
  compare_memory("relu_bw");
endtask

task automatic test_flatten();
  word_q_t a;
  int      rd0;
  int      wr0;
  repeat (12) a.push_back(lcg_next());
  load_words(128, a);
  rd0 = rd_count;
  wr0 = wr_count;
  run_job(make_job(FLATTEN, 128, 0, 160, 12), 0);
  foreach (a[i])
    exp_mem[8'(160 + i)] = a[i];
  compare_int("flatten reads", rd_count - rd0, 12);
  compare_int("flatten writes", wr_count - wr0, 12);
  compare_memory("flatten");
endtask

task automatic test_no_work();
  int rd0;
  int wr0;
  rd0 = rd_count;
  wr0 = wr_count;
  run_job(make_job(op_id_t'(4'h9), 0, 16, 64, 4), 0);
  run_job(make_job(RELU_FW, 0, 0, 64, 0), 0);
  compare_int("reads with no work", rd_count - rd0, 0);
  compare_int("writes with no work", wr_count - wr0, 0);
  compare_memory("no work");
endtask

task automatic test_back_pressure();
  word_q_t a;
  int      rd0;
  int      wr0;
  repeat (3) a.push_back(lcg_next());
  load_words(200, a);
  rd0 = rd_count;
  wr0 = wr_count;
  run_job(make_job(RELU_FW, 200, 0, 240, 3), 10);
  foreach (a[i])
    exp_mem[8'(240 + i)] = a[i][31] ? '0 : a[i];
  compare_int("back-pressure reads", rd_count - rd0, 3);
  compare_int("back-pressure writes", wr_count - wr0, 3);
  compare_memory("back-pressure");
endtask

`endif

// ==== testbench/tb_fpu_job_manager.sv ====
`include "fpu_config.svh"

module tb_fpu_job_manager
  import fpu_pkg::*;
  import mem_pkg::*;
();

  localparam int MEM_WORDS = 256;

  logic                clk;
  logic                rst_l;
  logic                req;
  job_desc_t           job;
  logic                ack;
  mem_req_t            mem_req;
  mem_rsp_t            mem_rsp = '0;
  logic [`COUNT_W-1:0] job_count;

  // Memory model with a preload port for the tests
  logic [`DATA_W-1:0] mem [MEM_WORDS];
  logic               load_we;
  logic [7:0]         load_addr;
  logic [`DATA_W-1:0] load_data;
  int                 rd_count;
  int                 wr_count;
  int                 err_count;
  int                 timeout_count;

  fpu_job_manager i_fpu_job_manager (
    .clk, .rst_l, .req, .job, .ack,
    .mem_req, .mem_rsp, .job_count
  );

  // Background pattern distinct at every address
  function automatic logic [`DATA_W-1:0] fill_word(input logic [7:0] addr);
    return {addr ^ 8'hC3, addr, ~addr, addr ^ 8'h5A};
  endfunction

  initial begin
    clk = 1'b0;
    forever #2 clk = ~clk;
  end

  always @(posedge clk) begin
    if (!rst_l) begin
      for (int i = 0; i < MEM_WORDS; i++)
        mem[8'(i)] = fill_word(8'(i));
      mem_rsp  <= '0;
      rd_count <= 0;
      wr_count <= 0;
    end else begin
      if (load_we)
        mem[load_addr] = load_data;
      // Read data is ready one cycle after re
      if (mem_req.re) begin
        mem_rsp.rdata <= mem[mem_req.addr[7:0]];
        rd_count      <= rd_count + 1;
      end
      if (mem_req.we) begin
        mem[mem_req.addr[7:0]] = mem_req.wdata;
        wr_count              <= wr_count + 1;
      end
    end
  end

  `include "tb_tests.svh"

  initial begin
    rst_l     <= 1'b0;
    req       <= 1'b0;
    job       <= '0;
    load_we   <= 1'b0;
    load_addr <= '0;
    load_data <= '0;
    err_count     = 0;
    timeout_count = 0;
    repeat (16) @(posedge clk);
    rst_l <= 1'b1;
    check_reset_state();
    test_relu_fw();
    test_relu_bw();
    test_flatten();
    test_no_work();
    test_back_pressure();
    $display("Errors: %0d wrong values, %0d timeouts", err_count, timeout_count);
    if (err_count == 0 && timeout_count == 0) begin
      $display("Done: no errors");
    end else begin
      $display("Done: errors found");
    end
    $finish;
  end

endmodule

// ==== testbench/fpu_job_manager_checker.sv ====
module fpu_job_manager_checker
  import mem_pkg::*;
(
  input logic     clk,
  input logic     rst_l,
  input logic     req,
  input logic     ack,
  input mem_req_t mem_req
);

  // ack only answers a pending req
  ack_needs_req: assert property (@(posedge clk) disable iff (!rst_l)
    $rose(ack) |-> req)
    else $error("ack rose with req low");

  one_access: assert property (@(posedge clk) disable iff (!rst_l)
    !(mem_req.re && mem_req.we))
    else $error("re and we high together");

  ack_held: assert property (@(posedge clk) disable iff (!rst_l)
    (ack && req) |=> ack)
    else $error("ack fell while req was high");

  // Memory port stays quiet once the job is acknowledged
  quiet_on_ack: assert property (@(posedge clk) disable iff (!rst_l)
    ack |-> !(mem_req.re || mem_req.we))
    else $error("memory access while ack high");

endmodule

bind fpu_job_manager fpu_job_manager_checker i_fpu_job_manager_checker (.*);

// ==== logic/fpu_job_manager.sv ====
`include "fpu_config.svh"

module fpu_job_manager
  import fpu_pkg::*;
  import mem_pkg::*;
(
  input  logic                clk,
  input  logic                rst_l,
  input  logic                req,
  input  job_desc_t           job,
  output logic                ack,
  output mem_req_t            mem_req,
  input  mem_rsp_t            mem_rsp,
  output logic [`COUNT_W-1:0] job_count
);

  logic       walk_start;
  logic       walk_finished;
  job_desc_t  walk_job;
  op_id_t     elem_op;
  fp32_word_u operand_a;
  fp32_word_u operand_b;
  fp32_word_u result;

  job_sequencer i_job_sequencer (
    .clk,
    .rst_l,
    .req,
    .job,
    .ack,
    .walk_start,
    .walk_job,
    .walk_finished,
    .job_count
  );

  region_walker i_region_walker (
    .clk,
    .rst_l,
    .walk_start,
    .walk_job,
    .walk_finished,
    .mem_req,
    .mem_rsp,
    .elem_op,
    .operand_a,
    .operand_b,
    .result
  );

  elem_datapath i_elem_datapath (
    .elem_op,
    .operand_a,
    .operand_b,
    .result
  );

endmodule

// ==== logic/elem_datapath.sv ====
module elem_datapath
  import fpu_pkg::*;
(
  input  op_id_t     elem_op,
  input  fp32_word_u operand_a,
  input  fp32_word_u operand_b,
  output fp32_word_u result
);

  logic a_zero;
  logic a_positive;

  // Both +0 and -0 count as zero
  assign a_zero     = (operand_a.f.exponent == '0) && (operand_a.f.mantissa == '0);
  assign a_positive = !operand_a.f.sign && !a_zero;

  always_comb begin
    result = '0;
    case (elem_op)
      RELU_FW: begin
        if (!operand_a.f.sign)
          result = operand_a;
      end
      RELU_BW: begin
        if (a_positive)
          result = operand_b;
      end
      FLATTEN: result = operand_a;
      default: result = '0;
    endcase
  end

endmodule

// ==== logic/region_walker.sv ====
`include "fpu_config.svh"

module region_walker
  import fpu_pkg::*;
  import mem_pkg::*;
(
  input  logic       clk,
  input  logic       rst_l,
  input  logic       walk_start,
  input  job_desc_t  walk_job,
  output logic       walk_finished,
  output mem_req_t   mem_req,
  input  mem_rsp_t   mem_rsp,
  output op_id_t     elem_op,
  output fp32_word_u operand_a,
  output fp32_word_u operand_b,
  input  fp32_word_u result
);

  typedef enum logic [1:0] {
    PH_IDLE,
    PH_RD_A,
    PH_RD_B,
    PH_WR
  } phase_t;

  phase_t              phase;
  logic [`COUNT_W-1:0] elem_idx;
  fp32_word_u          a_q;
  logic                two_operand;
  logic                last_elem;
  logic [`ADDR_W-1:0]  offset;

  assign two_operand = (walk_job.op == RELU_BW);
  assign last_elem   = (elem_idx + 1'b1 == walk_job.count);
  assign offset      = `ADDR_W'(elem_idx);

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      phase    <= PH_IDLE;
      elem_idx <= '0;
    end else begin
      case (phase)
        PH_IDLE: begin
          if (walk_start) begin
            phase    <= PH_RD_A;
            elem_idx <= '0;
          end
        end
        PH_RD_A: phase <= two_operand ? PH_RD_B : PH_WR;
        PH_RD_B: phase <= PH_WR;
        PH_WR: begin
          if (last_elem) begin
            phase <= PH_IDLE;
          end else begin
            phase    <= PH_RD_A;
            elem_idx <= elem_idx + 1'b1;
          end
        end
        default: phase <= PH_IDLE;
      endcase
    end
  end

  // A arrives while B is being read
  always_ff @(posedge clk) begin
    if (phase == PH_RD_B)
      a_q <= fp32_word_u'(mem_rsp.rdata);
  end

  always_comb begin
    mem_req = '0;
    case (phase)
      PH_RD_A: begin
        mem_req.re   = 1'b1;
        mem_req.addr = walk_job.base_a + offset;
      end
      PH_RD_B: begin
        mem_req.re   = 1'b1;
        mem_req.addr = walk_job.base_b + offset;
      end
      PH_WR: begin
        mem_req.we    = 1'b1;
        mem_req.addr  = walk_job.base_d + offset;
        mem_req.wdata = result.raw;
      end
      default: mem_req = '0;
    endcase
  end

  // In the write cycle rdata holds A, or B for two-operand jobs
  assign elem_op       = walk_job.op;
  assign operand_a     = two_operand ? a_q : fp32_word_u'(mem_rsp.rdata);
  assign operand_b     = fp32_word_u'(mem_rsp.rdata);
  assign walk_finished = (phase == PH_WR) && last_elem;

endmodule

// ==== logic/job_sequencer.sv ====
`include "fpu_config.svh"

module job_sequencer
  import fpu_pkg::*;
(
  input  logic                clk,
  input  logic                rst_l,
  input  logic                req,
  input  job_desc_t           job,
  output logic                ack,
  output logic                walk_start,
  output job_desc_t           walk_job,
  input  logic                walk_finished,
  output logic [`COUNT_W-1:0] job_count
);

  typedef enum logic [2:0] {
    S_IDLE,
    S_LATCH,
    S_RUN,
    S_ACK,
    S_RELEASE
  } seq_state_t;

  seq_state_t state, state_next;
  logic       job_runnable;
  logic       take_req;

  // Undefined codes and empty regions skip the walker
  assign job_runnable = (walk_job.op inside {RELU_FW, RELU_BW, FLATTEN}) &&
                        (walk_job.count != '0);

  // A new req may already be up in the release cycle
  assign take_req = ((state == S_IDLE) || (state == S_RELEASE)) && req;

  always_comb begin
    state_next = state;
    case (state)
      S_IDLE, S_RELEASE: state_next = req ? S_LATCH : S_IDLE;
      S_LATCH:           state_next = job_runnable ? S_RUN : S_ACK;
      S_RUN: begin
        if (walk_finished)
          state_next = S_ACK;
      end
      // Hold ack until the host lets go of req
      S_ACK: begin
        if (!req)
          state_next = S_RELEASE;
      end
      default:           state_next = S_IDLE;
    endcase
  end

  always_ff @(posedge clk, negedge rst_l) begin
    if (!rst_l) begin
      state     <= S_IDLE;
      job_count <= '0;
    end else begin
      state <= state_next;
      if (state == S_ACK && !req)
        job_count <= job_count + 1'b1;
    end
  end

  always_ff @(posedge clk) begin
    if (take_req)
      walk_job <= job;
  end

  assign walk_start = (state == S_LATCH) && job_runnable;
  assign ack        = (state == S_ACK);

endmodule

// ==== logic/mem_pkg.sv ====
`include "fpu_config.svh"

package mem_pkg;

  // One request per cycle, no back-pressure
  typedef struct packed {
    logic               re;
    logic               we;
    logic [`ADDR_W-1:0] addr;
    logic [`DATA_W-1:0] wdata;
  } mem_req_t;

  // Valid the cycle after re
  typedef struct packed {
    logic [`DATA_W-1:0] rdata;
  } mem_rsp_t;

endpackage

// ==== logic/fpu_pkg.sv ====
`include "fpu_config.svh"

package fpu_pkg;

  // Codes outside these three are accepted and completed with no work
  typedef enum logic [3:0] {
    RELU_FW = 4'h1,
    RELU_BW = 4'h2,
    FLATTEN = 4'h3
  } op_id_t;

  typedef struct packed {
    logic        sign;
    logic [7:0]  exponent;
    logic [22:0] mantissa;
  } fp32_fields_t;

  // IEEE single precision, seen as bits or as fields
  typedef union packed {
    logic [`DATA_W-1:0] raw;
    fp32_fields_t       f;
  } fp32_word_u;

  typedef struct packed {
    op_id_t              op;
    logic [`ADDR_W-1:0]  base_a;
    logic [`ADDR_W-1:0]  base_b;
    logic [`ADDR_W-1:0]  base_d;
    logic [`COUNT_W-1:0] count;
  } job_desc_t;

endpackage

// ==== include/fpu_config.svh ====
`ifndef FPU_CONFIG_SVH
`define FPU_CONFIG_SVH

// Memory port widths
`define ADDR_W 16
`define DATA_W 32

// Element count and completed-job counter width
`define COUNT_W 16

// Cycles allowed for any single wait in the testbench
`define TB_TIMEOUT 2000

`endif
